// File: hdl/segre_config.svh
`ifndef SEGRE_CONFIG_SVH
`define SEGRE_CONFIG_SVH

// ----------------------------------------------------------------------
// Hazard subsystem sizing
// ----------------------------------------------------------------------

// Architectural register tag, x0 to x31.
`define SEGRE_REG_SIZE 5

// Stages in the multiply unit, rvm1 to rvm5.
// The bypass priority in the controller is written for exactly this depth.
`define SEGRE_RVM_DEPTH 5

`endif

// File: hdl/segre_pkg.sv
`include "segre_config.svh"

package segre_pkg;

    // ----------------------------------------------------------------------
    // Opcode classes as seen by the hazard logic
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        OPCODE_NONE   = 3'd0,  // Bubble or unknown.
        OPCODE_OP     = 3'd1,
        OPCODE_OP_IMM = 3'd2,
        OPCODE_LOAD   = 3'd3,
        OPCODE_STORE  = 3'd4,
        OPCODE_RVM    = 3'd5   // Multiply unit.
    } opcode_e;

    // ----------------------------------------------------------------------
    // Operand bypass select
    // ----------------------------------------------------------------------
    // Names read as BY_<producer stage>_<consumer stage>.
    typedef enum logic [3:0] {
        NO_BYPASS    = 4'd0,   // Operand comes from the register file.
        BY_EX_PIPE   = 4'd1,
        BY_EX_ID     = 4'd2,
        BY_MEM_ID    = 4'd3,
        BY_MEM_PIPE  = 4'd4,
        BY_MEM_TL    = 4'd5,   // Store data only.
        BY_RVM5_ID   = 4'd6,
        BY_RVM5_PIPE = 4'd7,
        BY_RVM5_TL   = 4'd8    // Store data only.
    } bypass_e;

    // ----------------------------------------------------------------------
    // Destination tags of everything below id
    // ----------------------------------------------------------------------
    // A tag of 0 marks an empty stage or an instruction with no result.
    typedef struct packed {
        logic [`SEGRE_REG_SIZE-1:0] ex_wreg;
        logic [`SEGRE_REG_SIZE-1:0] alu_mem_wreg;
        logic [`SEGRE_REG_SIZE-1:0] tl_wreg;
        logic [`SEGRE_REG_SIZE-1:0] mem_wreg;
        logic [`SEGRE_REG_SIZE-1:0] rvm1_wreg;
        logic [`SEGRE_REG_SIZE-1:0] rvm2_wreg;
        logic [`SEGRE_REG_SIZE-1:0] rvm3_wreg;
        logic [`SEGRE_REG_SIZE-1:0] rvm4_wreg;
        logic [`SEGRE_REG_SIZE-1:0] rvm5_wreg;
    } bypass_data_t;

    // Single cycle ALU classes, result ready at the end of ex.
    function automatic logic is_alu_op(opcode_e op);
        return (op == OPCODE_OP) || (op == OPCODE_OP_IMM);
    endfunction

    // Classes that travel down the memory path.
    function automatic logic is_mem_op(opcode_e op);
        return (op == OPCODE_LOAD) || (op == OPCODE_STORE);
    endfunction

    // Classes that write a destination register.
    function automatic logic has_wreg(opcode_e op);
        return is_alu_op(op) || (op == OPCODE_LOAD) || (op == OPCODE_RVM);
    endfunction

endpackage : segre_pkg

// File: hdl/segre_wreg_if.sv
`timescale 1ns/10ps
`include "segre_config.svh"

interface segre_wreg_if;

    // Instruction currently in id.
    logic [`SEGRE_REG_SIZE-1:0] id_wreg;
    segre_pkg::opcode_e         id_opcode;

    // Producers further down the three paths.
    segre_pkg::bypass_data_t    stages;

    // ----------------------------------------------------------------------
    // Views
    // ----------------------------------------------------------------------
    modport tracker (
        output id_wreg,
        output id_opcode,
        output stages
    );

    modport controller (
        input  id_wreg,
        input  id_opcode,
        input  stages
    );

endinterface : segre_wreg_if

// File: hdl/segre_wreg_tracker.sv
`timescale 1ns/10ps
`include "segre_config.svh"

module segre_wreg_tracker (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    // Issue side.
    input  logic                       accept_i,
    input  logic [`SEGRE_REG_SIZE-1:0] dst_i,
    input  segre_pkg::opcode_e         opcode_i,

    // Tracked destinations.
    segre_wreg_if.tracker              wreg
);

    logic [`SEGRE_REG_SIZE-1:0] id_wreg_d;
    logic [`SEGRE_REG_SIZE-1:0] id_wreg_q;
    segre_pkg::opcode_e         id_opcode_d;
    segre_pkg::opcode_e         id_opcode_q;

    logic [`SEGRE_REG_SIZE-1:0] ex_wreg_d;
    logic [`SEGRE_REG_SIZE-1:0] ex_wreg_q;
    logic [`SEGRE_REG_SIZE-1:0] alu_mem_wreg_d;
    logic [`SEGRE_REG_SIZE-1:0] alu_mem_wreg_q;
    logic [`SEGRE_REG_SIZE-1:0] tl_wreg_q;
    logic [`SEGRE_REG_SIZE-1:0] mem_wreg_q;

    logic [`SEGRE_REG_SIZE-1:0] rvm_wreg_d;
    logic [`SEGRE_REG_SIZE-1:0] rvm_wreg_q [`SEGRE_RVM_DEPTH]; // Index 0 is rvm1.

    // ----------------------------------------------------------------------
    // Entry into id
    // ----------------------------------------------------------------------
    always_comb begin : id_entry
        id_wreg_d   = '0;
        id_opcode_d = segre_pkg::OPCODE_NONE;   // Bubble by default.

        if (accept_i) begin
            id_opcode_d = opcode_i;
            // Stores and classes without a result carry no producer.
            if (segre_pkg::has_wreg(opcode_i)) begin
                id_wreg_d = dst_i;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Path steering out of id
    // ----------------------------------------------------------------------
    always_comb begin : path_steer
        ex_wreg_d      = '0;
        alu_mem_wreg_d = '0;
        rvm_wreg_d     = '0;

        if (segre_pkg::is_alu_op(id_opcode_q)) begin
            ex_wreg_d = id_wreg_q;
        end
        else if (segre_pkg::is_mem_op(id_opcode_q)) begin
            alu_mem_wreg_d = id_wreg_q;
        end
        else if (id_opcode_q == segre_pkg::OPCODE_RVM) begin
            rvm_wreg_d = id_wreg_q;
        end
    end

    // ----------------------------------------------------------------------
    // Stage registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id_wreg_q      <= '0;
            id_opcode_q    <= segre_pkg::OPCODE_NONE;
            ex_wreg_q      <= '0;
            alu_mem_wreg_q <= '0;
            tl_wreg_q      <= '0;
            mem_wreg_q     <= '0;
            for (int i = 0; i < `SEGRE_RVM_DEPTH; i++) begin
                rvm_wreg_q[i] <= '0;
            end
        end
        else begin
            id_wreg_q      <= id_wreg_d;
            id_opcode_q    <= id_opcode_d;
            ex_wreg_q      <= ex_wreg_d;      // ALU result leaves after ex.
            alu_mem_wreg_q <= alu_mem_wreg_d;
            tl_wreg_q      <= alu_mem_wreg_q;
            mem_wreg_q     <= tl_wreg_q;
            rvm_wreg_q[0]  <= rvm_wreg_d;
            for (int i = 1; i < `SEGRE_RVM_DEPTH; i++) begin
                rvm_wreg_q[i] <= rvm_wreg_q[i-1];
            end
        end
    end

    // ----------------------------------------------------------------------
    // Publish to the controller
    // ----------------------------------------------------------------------
    assign wreg.id_wreg   = id_wreg_q;
    assign wreg.id_opcode = id_opcode_q;

    assign wreg.stages = '{
        ex_wreg:      ex_wreg_q,
        alu_mem_wreg: alu_mem_wreg_q,
        tl_wreg:      tl_wreg_q,
        mem_wreg:     mem_wreg_q,
        rvm1_wreg:    rvm_wreg_q[0],
        rvm2_wreg:    rvm_wreg_q[1],
        rvm3_wreg:    rvm_wreg_q[2],
        rvm4_wreg:    rvm_wreg_q[3],
        rvm5_wreg:    rvm_wreg_q[`SEGRE_RVM_DEPTH-1]
    };

endmodule : segre_wreg_tracker

// File: hdl/segre_bypass_controller.sv
`timescale 1ns/10ps
`include "segre_config.svh"

module segre_bypass_controller (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    // Sources of the instruction waiting at issue.
    input  logic [`SEGRE_REG_SIZE-1:0] src_a_i,
    input  logic [`SEGRE_REG_SIZE-1:0] src_b_i,
    input  segre_pkg::opcode_e         instr_opcode_i,

    // In flight producers.
    segre_wreg_if.controller           wreg,

    output segre_pkg::bypass_e         bypass_a_o,
    output segre_pkg::bypass_e         bypass_b_o,
    output logic                       dependence_o
);

    logic active_q;
    logic enable;
    logic id_alu;
    logic dep_a;
    logic dep_b;

    // Decisions open once the tracker has come out of reset cleared.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
        end
        else begin
            active_q <= 1'b1;
        end
    end

    assign enable = rst_n_i & active_q;
    assign id_alu = segre_pkg::is_alu_op(wreg.id_opcode);

    // ----------------------------------------------------------------------
    // Operand A
    // ----------------------------------------------------------------------
    always_comb begin : operand_a
        bypass_a_o = segre_pkg::NO_BYPASS;
        dep_a      = 1'b0;

        if (enable && src_a_i != '0) begin
            if (src_a_i == wreg.id_wreg) begin
                if (id_alu) begin
                    bypass_a_o = segre_pkg::BY_EX_PIPE;
                end
                else begin
                    dep_a = 1'b1;   // Load or multiply in id.
                end
            end
            else if (src_a_i == wreg.stages.ex_wreg) begin
                bypass_a_o = segre_pkg::BY_EX_ID;
            end
            else if (src_a_i == wreg.stages.mem_wreg) begin
                bypass_a_o = segre_pkg::BY_MEM_ID;
            end
            else if (src_a_i == wreg.stages.rvm5_wreg) begin
                bypass_a_o = segre_pkg::BY_RVM5_ID;
            end
            else if (src_a_i == wreg.stages.rvm4_wreg) begin
                bypass_a_o = segre_pkg::BY_RVM5_PIPE;
            end
            else if (src_a_i == wreg.stages.tl_wreg) begin
                bypass_a_o = segre_pkg::BY_MEM_PIPE;
            end
            else if (src_a_i == wreg.stages.alu_mem_wreg ||
                     src_a_i == wreg.stages.rvm1_wreg    ||
                     src_a_i == wreg.stages.rvm2_wreg    ||
                     src_a_i == wreg.stages.rvm3_wreg) begin
                dep_a = 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Operand B, also the store data operand
    // ----------------------------------------------------------------------
    always_comb begin : operand_b
        bypass_b_o = segre_pkg::NO_BYPASS;
        dep_b      = 1'b0;

        if (enable && src_b_i != '0) begin
            if (src_b_i == wreg.id_wreg) begin
                if (id_alu) begin
                    bypass_b_o = segre_pkg::BY_EX_PIPE;
                end
                else begin
                    dep_b = 1'b1;
                end
            end
            else if (src_b_i == wreg.stages.alu_mem_wreg) begin
                bypass_b_o = segre_pkg::BY_MEM_TL;  // Late use of B.
            end
            else if (src_b_i == wreg.stages.ex_wreg) begin
                bypass_b_o = segre_pkg::BY_EX_ID;
            end
            else if (src_b_i == wreg.stages.mem_wreg) begin
                bypass_b_o = segre_pkg::BY_MEM_ID;
            end
            else if (src_b_i == wreg.stages.rvm5_wreg) begin
                bypass_b_o = segre_pkg::BY_RVM5_ID;
            end
            else if (src_b_i == wreg.stages.rvm4_wreg) begin
                bypass_b_o = segre_pkg::BY_RVM5_PIPE;
            end
            else if (src_b_i == wreg.stages.tl_wreg) begin
                bypass_b_o = segre_pkg::BY_MEM_PIPE;
            end
            else if (src_b_i == wreg.stages.rvm3_wreg &&
                     instr_opcode_i == segre_pkg::OPCODE_STORE) begin
                bypass_b_o = segre_pkg::BY_RVM5_TL;  // Store data meets rvm5 in tl.
            end
            else if (src_b_i == wreg.stages.rvm1_wreg ||
                     src_b_i == wreg.stages.rvm2_wreg ||
                     src_b_i == wreg.stages.rvm3_wreg) begin
                dep_b = 1'b1;
            end
        end
    end

    assign dependence_o = dep_a | dep_b;

endmodule : segre_bypass_controller

// File: hdl/segre_hazard_top.sv
`timescale 1ns/10ps
`include "segre_config.svh"

module segre_hazard_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    // Decode side.
    input  logic                       instr_valid_i,
    input  logic [`SEGRE_REG_SIZE-1:0] src_a_i,
    input  logic [`SEGRE_REG_SIZE-1:0] src_b_i,
    input  logic [`SEGRE_REG_SIZE-1:0] dst_i,
    input  segre_pkg::opcode_e         instr_opcode_i,

    // Issue side.
    output segre_pkg::bypass_e         bypass_a_o,
    output segre_pkg::bypass_e         bypass_b_o,
    output logic                       stall_o
);

    logic accept;
    logic dependence;

    segre_wreg_if wreg_if ();

    // ----------------------------------------------------------------------
    // Issue rule
    // ----------------------------------------------------------------------
    assign accept  = instr_valid_i & ~dependence;   // Otherwise a bubble enters id.
    assign stall_o = instr_valid_i &  dependence;

    // ----------------------------------------------------------------------
    // Datapath tag tracking and bypass selection
    // ----------------------------------------------------------------------
    segre_wreg_tracker segre_wreg_tracker_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .accept_i (accept),
        .dst_i    (dst_i),
        .opcode_i (instr_opcode_i),
        .wreg     (wreg_if.tracker)
    );

    segre_bypass_controller segre_bypass_controller_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .src_a_i        (src_a_i),
        .src_b_i        (src_b_i),
        .instr_opcode_i (instr_opcode_i),
        .wreg           (wreg_if.controller),
        .bypass_a_o     (bypass_a_o),
        .bypass_b_o     (bypass_b_o),
        .dependence_o   (dependence)
    );

endmodule : segre_hazard_top

// File: tb/segre_hazard_tb.sv
`timescale 1ns/10ps
`include "segre_config.svh"

module segre_hazard_tb;

    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 120;
    localparam int RANDOM_INSTRS   = 400;
    // Worst case per random instruction is one bubble plus four stalls and the issue.
    localparam int CYCLE_LIMIT = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_INSTRS * 6) * 2;

    logic                       clk_i;
    logic                       rst_n_i;
    logic                       instr_valid_i;
    logic [`SEGRE_REG_SIZE-1:0] src_a_i;
    logic [`SEGRE_REG_SIZE-1:0] src_b_i;
    logic [`SEGRE_REG_SIZE-1:0] dst_i;
    segre_pkg::opcode_e         instr_opcode_i;
    segre_pkg::bypass_e         bypass_a_o;
    segre_pkg::bypass_e         bypass_b_o;
    logic                       stall_o;

    string test_name = "reset";
    int    directed_errors = 0;
    int    compare_errors = 0;
    int    cycle_count = 0;
    logic [31:0] lfsr_state = 32'h5eab_2bff;

    // Shadow copy of the tag pipeline.
    logic [`SEGRE_REG_SIZE-1:0] sh_id_tag = '0;
    segre_pkg::opcode_e         sh_id_op = segre_pkg::OPCODE_NONE;
    segre_pkg::bypass_data_t    sh_st = '0;

    segre_hazard_top segre_hazard_top_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .src_a_i        (src_a_i),
        .src_b_i        (src_b_i),
        .dst_i          (dst_i),
        .instr_opcode_i (instr_opcode_i),
        .bypass_a_o     (bypass_a_o),
        .bypass_b_o     (bypass_b_o),
        .stall_o        (stall_o)
    );

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // Random numbers
    // ------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1.
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    function automatic segre_pkg::opcode_e pick_opcode(input logic [2:0] r);
        case (r)
            3'd0, 3'd5: return segre_pkg::OPCODE_OP;
            3'd1, 3'd6: return segre_pkg::OPCODE_OP_IMM;
            3'd2, 3'd7: return segre_pkg::OPCODE_LOAD;
            3'd3:       return segre_pkg::OPCODE_STORE;
            default:    return segre_pkg::OPCODE_RVM;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    // Result is {dependence, select} for one operand.
    function automatic logic [4:0] operand_choice(
        input logic [`SEGRE_REG_SIZE-1:0] src,
        input logic                       is_b,
        input segre_pkg::opcode_e         op,
        input logic [`SEGRE_REG_SIZE-1:0] id_tag,
        input segre_pkg::opcode_e         id_op,
        input segre_pkg::bypass_data_t    st
    );
        logic [4:0] res;
        res = {1'b0, segre_pkg::NO_BYPASS};
        if (src == '0) begin
            return res;                  // x0 is never produced.
        end
        if (src == id_tag) begin
            if (id_op == segre_pkg::OPCODE_OP || id_op == segre_pkg::OPCODE_OP_IMM) begin
                res[3:0] = segre_pkg::BY_EX_PIPE;
            end
            else begin
                res[4] = 1'b1;
            end
        end
        else if (is_b && src == st.alu_mem_wreg) res[3:0] = segre_pkg::BY_MEM_TL;
        else if (src == st.ex_wreg)              res[3:0] = segre_pkg::BY_EX_ID;
        else if (src == st.mem_wreg)             res[3:0] = segre_pkg::BY_MEM_ID;
        else if (src == st.rvm5_wreg)            res[3:0] = segre_pkg::BY_RVM5_ID;
        else if (src == st.rvm4_wreg)            res[3:0] = segre_pkg::BY_RVM5_PIPE;
        else if (src == st.tl_wreg)              res[3:0] = segre_pkg::BY_MEM_PIPE;
        else if (is_b && src == st.rvm3_wreg && op == segre_pkg::OPCODE_STORE) begin
            res[3:0] = segre_pkg::BY_RVM5_TL;
        end
        else if (!is_b && src == st.alu_mem_wreg) res[4] = 1'b1;
        else if (src == st.rvm1_wreg || src == st.rvm2_wreg || src == st.rvm3_wreg) begin
            res[4] = 1'b1;
        end
        return res;
    endfunction

    // Result is {bypass_a, bypass_b, stall}.
    function automatic logic [8:0] ref_outputs(
        input logic [`SEGRE_REG_SIZE-1:0] a,
        input logic [`SEGRE_REG_SIZE-1:0] b,
        input segre_pkg::opcode_e         op,
        input logic                       valid,
        input logic                       en,
        input logic [`SEGRE_REG_SIZE-1:0] id_tag,
        input segre_pkg::opcode_e         id_op,
        input segre_pkg::bypass_data_t    st
    );
        logic [4:0] ra;
        logic [4:0] rb;
        if (!en) begin
            return '0;
        end
        ra = operand_choice(a, 1'b0, op, id_tag, id_op, st);
        rb = operand_choice(b, 1'b1, op, id_tag, id_op, st);
        return {ra[3:0], rb[3:0], valid & (ra[4] | rb[4])};
    endfunction

    task automatic update_shadow(input logic rst_n, input logic accept,
                                 input logic [`SEGRE_REG_SIZE-1:0] dst,
                                 input segre_pkg::opcode_e op);
        segre_pkg::bypass_data_t nx;
        if (!rst_n) begin
            sh_id_tag = '0;
            sh_id_op  = segre_pkg::OPCODE_NONE;
            sh_st     = '0;
            return;
        end
        nx = '0;
        case (sh_id_op)
            segre_pkg::OPCODE_OP, segre_pkg::OPCODE_OP_IMM: nx.ex_wreg = sh_id_tag;
            segre_pkg::OPCODE_LOAD, segre_pkg::OPCODE_STORE: nx.alu_mem_wreg = sh_id_tag;
            segre_pkg::OPCODE_RVM: nx.rvm1_wreg = sh_id_tag;
            default: ;
        endcase
        nx.tl_wreg   = sh_st.alu_mem_wreg;
        nx.mem_wreg  = sh_st.tl_wreg;
        nx.rvm2_wreg = sh_st.rvm1_wreg;
        nx.rvm3_wreg = sh_st.rvm2_wreg;
        nx.rvm4_wreg = sh_st.rvm3_wreg;
        nx.rvm5_wreg = sh_st.rvm4_wreg;
        sh_st     = nx;
        sh_id_op  = accept ? op : segre_pkg::OPCODE_NONE;
        sh_id_tag = (accept && op != segre_pkg::OPCODE_STORE
                     && op != segre_pkg::OPCODE_NONE) ? dst : '0;
    endtask

    // ------------------------------------------------------------------
    // Comparing process, one sample per cycle just before the edge
    // ------------------------------------------------------------------
    initial begin : compare
        logic [8:0]         exp;
        segre_pkg::bypass_e exp_a;
        segre_pkg::bypass_e exp_b;
        logic               exp_stall;
        forever begin
            @(posedge clk_i);
            #3;
            exp = ref_outputs(src_a_i, src_b_i, instr_opcode_i, instr_valid_i,
                              rst_n_i, sh_id_tag, sh_id_op, sh_st);
            exp_a     = segre_pkg::bypass_e'(exp[8:5]);
            exp_b     = segre_pkg::bypass_e'(exp[4:1]);
            exp_stall = exp[0];
            assert (bypass_a_o === exp_a) else begin
                compare_errors++;
                $display("Mismatch %s bypass_a: expected %s actual %s",
                         test_name, exp_a.name(), bypass_a_o.name());
            end
            assert (bypass_b_o === exp_b) else begin
                compare_errors++;
                $display("Mismatch %s bypass_b: expected %s actual %s",
                         test_name, exp_b.name(), bypass_b_o.name());
            end
            assert (stall_o === exp_stall) else begin
                compare_errors++;
                $display("Mismatch %s stall: expected %0b actual %0b",
                         test_name, exp_stall, stall_o);
            end
            update_shadow(rst_n_i, instr_valid_i && !exp_stall, dst_i, instr_opcode_i);
        end
    end

    initial begin : watchdog
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failures found");
        $finish;
    end

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------
    task automatic drive_instr(input logic v, input segre_pkg::opcode_e op,
                               input logic [`SEGRE_REG_SIZE-1:0] a,
                               input logic [`SEGRE_REG_SIZE-1:0] b,
                               input logic [`SEGRE_REG_SIZE-1:0] d);
        instr_valid_i  = v;
        instr_opcode_i = op;
        src_a_i        = a;
        src_b_i        = b;
        dst_i          = d;
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic idle(input int n);
        drive_instr(1'b0, segre_pkg::OPCODE_NONE, '0, '0, '0);
        repeat (n) next_cycle();
    endtask

    // Mid-cycle check of the directed expectations.
    task automatic expect_out(input segre_pkg::bypass_e ea, input segre_pkg::bypass_e eb,
                              input logic es);
        @(negedge clk_i);
        assert (bypass_a_o === ea && bypass_b_o === eb && stall_o === es) else begin
            directed_errors++;
            $display("Mismatch %s: expected %s/%s/%0b actual %s/%s/%0b", test_name,
                     ea.name(), eb.name(), es, bypass_a_o.name(), bypass_b_o.name(), stall_o);
        end
    endtask

    // Hold the driven instruction until the DUT takes it.
    task automatic wait_accept();
        logic held;
        held = 1'b1;
        while (held) begin
            @(negedge clk_i);
            held = stall_o;
            next_cycle();
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin : stimulus
        logic [7:0]         r;
        logic [7:0]         ra;
        logic [7:0]         rb;
        logic [7:0]         rd;
        segre_pkg::opcode_e op;

        rst_n_i = 1'b0;
        drive_instr(1'b1, segre_pkg::OPCODE_OP, 5'd1, 5'd2, 5'd1);
        repeat (RESET_CYCLES - 1) @(posedge clk_i);
        expect_out(segre_pkg::NO_BYPASS, segre_pkg::NO_BYPASS, 1'b0);
        @(posedge clk_i);
        #1 rst_n_i = 1'b1;
        expect_out(segre_pkg::NO_BYPASS, segre_pkg::NO_BYPASS, 1'b0);
        next_cycle();
        idle(7);

        test_name = "alu_forward";
        drive_instr(1'b1, segre_pkg::OPCODE_OP, 5'd2, 5'd3, 5'd1);
        expect_out(segre_pkg::NO_BYPASS, segre_pkg::NO_BYPASS, 1'b0);
        next_cycle();
        drive_instr(1'b1, segre_pkg::OPCODE_OP, 5'd1, 5'd1, 5'd4);
        expect_out(segre_pkg::BY_EX_PIPE, segre_pkg::BY_EX_PIPE, 1'b0);
        next_cycle();
        idle(7);
        drive_instr(1'b1, segre_pkg::OPCODE_OP_IMM, 5'd0, 5'd0, 5'd5);
        next_cycle();
        idle(1);
        drive_instr(1'b1, segre_pkg::OPCODE_OP, 5'd5, 5'd2, 5'd0);
        expect_out(segre_pkg::BY_EX_ID, segre_pkg::NO_BYPASS, 1'b0);
        next_cycle();
        idle(7);

        test_name = "load_use";
        drive_instr(1'b1, segre_pkg::OPCODE_LOAD, 5'd0, 5'd0, 5'd6);
        next_cycle();
        drive_instr(1'b1, segre_pkg::OPCODE_OP, 5'd6, 5'd6, 5'd7);
        expect_out(segre_pkg::NO_BYPASS, segre_pkg::NO_BYPASS, 1'b1);
        next_cycle();
        expect_out(segre_pkg::NO_BYPASS, segre_pkg::BY_MEM_TL, 1'b1);   // Still held.
        next_cycle();
        expect_out(segre_pkg::BY_MEM_PIPE, segre_pkg::BY_MEM_PIPE, 1'b0);
        next_cycle();
        drive_instr(1'b1, segre_pkg::OPCODE_OP, 5'd6, 5'd0, 5'd8);
        expect_out(segre_pkg::BY_MEM_ID, segre_pkg::NO_BYPASS, 1'b0);
        next_cycle();
        idle(7);
        drive_instr(1'b1, segre_pkg::OPCODE_LOAD, 5'd0, 5'd0, 5'd9);
        next_cycle();
        idle(1);
        drive_instr(1'b1, segre_pkg::OPCODE_STORE, 5'd0, 5'd9, 5'd0);
        expect_out(segre_pkg::NO_BYPASS, segre_pkg::BY_MEM_TL, 1'b0);
        next_cycle();
        idle(7);

        test_name = "multiply";
        drive_instr(1'b1, segre_pkg::OPCODE_RVM, 5'd0, 5'd0, 5'd10);
        next_cycle();
        drive_instr(1'b1, segre_pkg::OPCODE_OP, 5'd10, 5'd0, 5'd11);
        repeat (4) begin
            expect_out(segre_pkg::NO_BYPASS, segre_pkg::NO_BYPASS, 1'b1);   // id, rvm1 to rvm3.
            next_cycle();
        end
        expect_out(segre_pkg::BY_RVM5_PIPE, segre_pkg::NO_BYPASS, 1'b0);
        next_cycle();
        drive_instr(1'b1, segre_pkg::OPCODE_OP, 5'd10, 5'd10, 5'd12);
        expect_out(segre_pkg::BY_RVM5_ID, segre_pkg::BY_RVM5_ID, 1'b0);
        next_cycle();
        idle(7);
        drive_instr(1'b1, segre_pkg::OPCODE_RVM, 5'd0, 5'd0, 5'd13);
        next_cycle();
        drive_instr(1'b1, segre_pkg::OPCODE_STORE, 5'd0, 5'd13, 5'd0);
        repeat (3) begin
            expect_out(segre_pkg::NO_BYPASS, segre_pkg::NO_BYPASS, 1'b1);
            next_cycle();
        end
        expect_out(segre_pkg::NO_BYPASS, segre_pkg::BY_RVM5_TL, 1'b0);
        next_cycle();
        idle(7);

        test_name = "reg0_and_hold";
        drive_instr(1'b1, segre_pkg::OPCODE_OP, 5'd0, 5'd0, 5'd0);
        next_cycle();
        drive_instr(1'b1, segre_pkg::OPCODE_LOAD, 5'd0, 5'd0, 5'd3);
        expect_out(segre_pkg::NO_BYPASS, segre_pkg::NO_BYPASS, 1'b0);
        next_cycle();
        idle(7);
        drive_instr(1'b1, segre_pkg::OPCODE_LOAD, 5'd0, 5'd0, 5'd14);
        next_cycle();
        drive_instr(1'b1, segre_pkg::OPCODE_OP, 5'd0, 5'd14, 5'd15);
        expect_out(segre_pkg::NO_BYPASS, segre_pkg::NO_BYPASS, 1'b1);
        next_cycle();
        expect_out(segre_pkg::NO_BYPASS, segre_pkg::BY_MEM_TL, 1'b0);
        next_cycle();
        drive_instr(1'b1, segre_pkg::OPCODE_OP, 5'd15, 5'd0, 5'd0);
        expect_out(segre_pkg::BY_EX_PIPE, segre_pkg::NO_BYPASS, 1'b0);  // Held one got in.
        next_cycle();
        idle(7);

        test_name = "reset_in_flight";
        drive_instr(1'b1, segre_pkg::OPCODE_LOAD, 5'd0, 5'd0, 5'd16);
        next_cycle();
        drive_instr(1'b1, segre_pkg::OPCODE_OP, 5'd16, 5'd16, 5'd17);
        rst_n_i = 1'b0;
        expect_out(segre_pkg::NO_BYPASS, segre_pkg::NO_BYPASS, 1'b0);   // Load still in id.
        repeat (RESET_CYCLES) next_cycle();
        rst_n_i = 1'b1;
        expect_out(segre_pkg::NO_BYPASS, segre_pkg::NO_BYPASS, 1'b0);
        next_cycle();
        idle(7);

        test_name = "random";
        for (int n = 0; n < RANDOM_INSTRS; n++) begin
            take_bits(3, r);
            if (r[2:0] == 3'd0) begin
                idle(1);
            end
            take_bits(3, r);
            op = pick_opcode(r[2:0]);
            take_bits(3, ra);
            take_bits(3, rb);
            take_bits(3, rd);
            drive_instr(1'b1, op, ra[4:0], rb[4:0], rd[4:0]);
            wait_accept();
        end
        idle(8);

        $display("Error counts: directed %0d, reference compare %0d",
                 directed_errors, compare_errors);
        if (directed_errors == 0 && compare_errors == 0) begin
            $display("All tests passed!");
        end
        else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : segre_hazard_tb

// File: src.f
+incdir+hdl
hdl/segre_pkg.sv
hdl/segre_wreg_if.sv
hdl/segre_wreg_tracker.sv
hdl/segre_bypass_controller.sv
hdl/segre_hazard_top.sv
tb/segre_hazard_tb.sv
